//--- dv/sample_xfer_tb.sv
`timescale 1ns/1ns

module sample_xfer_tb
	import xfer_pkg::*;
();

	// Event, slice and read totals over all tests
	localparam int N_EVT = 15;
	localparam int N_SLICES = N_EVT * SLICES_PER_EVT + 4;
	localparam int N_READS = N_EVT * EVT_WORDS;
	localparam int CYCLE_LIMIT = 400 * N_EVT + 4 * N_SLICES + 2 * N_READS + 500;

	logic CLK;
	logic RST;
	logic slice_we;
	slice_t slice_in;
	logic trig;
	logic jtag_mode;
	logic jtag_rd;
	logic rb_rd;
	slice_t jtag_slice;
	rb_word_t rb_dout;
	logic rb_empty;
	logic busy;

	// Reference model
	slice_t slice_q[$];
	rb_word_t exp_q[$];
	sample_t pend_evt[$];
	sample_t trig_cnt;
	int unsigned lcg_state;
	int cycles = 0;

	sample_xfer_top UUT (
		.CLK        (CLK),
		.RST        (RST),
		.slice_we   (slice_we),
		.slice_in   (slice_in),
		.trig       (trig),
		.jtag_mode  (jtag_mode),
		.jtag_rd    (jtag_rd),
		.rb_rd      (rb_rd),
		.jtag_slice (jtag_slice),
		.rb_dout    (rb_dout),
		.rb_empty   (rb_empty),
		.busy       (busy)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles > CYCLE_LIMIT)
			abort_run("Timeout, the run took longer than the tests allow");
	end

	//////////////////////////////
	// Helpers and checks
	//////////////////////////////

	function automatic int unsigned next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic compare_word(input string name, input rb_word_t got, input rb_word_t exp);
		if (got !== exp)
			abort_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic compare_slice(input string name, input slice_t got, input slice_t exp);
		if (got !== exp)
			abort_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
	endtask

	// Random gap first, so a transfer can only start after the task returns
	task automatic write_slice();
		slice_t s;
		for (int c = 0; c < NUM_CHAN; c++)
			s[c] = sample_t'(next_rand());
		repeat (next_rand() % 3) @(posedge CLK);
		@(posedge CLK);
		slice_we <= 1'b1;
		slice_in <= s;
		@(posedge CLK);
		slice_we <= 1'b0;
		slice_q.push_back(s);
	endtask

	task automatic send_trig();
		@(posedge CLK);
		trig <= 1'b1;
		@(posedge CLK);
		trig <= 1'b0;
		pend_evt.push_back(trig_cnt);
		trig_cnt = trig_cnt + 1'b1;
	endtask

	task automatic jtag_pop();
		@(posedge CLK);
		jtag_rd <= 1'b1;
		@(posedge CLK);
		jtag_rd <= 1'b0;
		void'(slice_q.pop_front());
		@(negedge CLK);
		compare_slice("jtag_slice", jtag_slice, slice_q[0]);
		compare_bit("busy", busy, 1'b0);
	endtask

	// Waits out one transfer and appends its words to the model
	task automatic run_event();
		int len;
		slice_t s;
		rb_word_t w;
		@(negedge CLK);
		while (!busy)
			@(negedge CLK);
		len = 0;
		while (busy) begin
			len++;
			@(negedge CLK);
		end
		if (len != EVT_WORDS + 1)
			abort_run($sformatf("busy was high for %0d cycles instead of %0d", len, EVT_WORDS + 1));
		if (pend_evt.size() == 0 || slice_q.size() < SLICES_PER_EVT)
			abort_run("A transfer started without a complete event in the model");
		w.hdr = 1'b1;
		w.data = pend_evt.pop_front();
		exp_q.push_back(w);
		// Sample time, then chip, then channel
		for (int k = 0; k < SLICES_PER_EVT; k++) begin
			s = slice_q.pop_front();
			for (int c = 0; c < NUM_CHAN; c++) begin
				w.hdr = 1'b0;
				w.data = s[c];
				exp_q.push_back(w);
			end
		end
	endtask

	task automatic read_words(input int n, input logic hold_idle);
		rb_word_t exp;
		@(negedge CLK);
		for (int i = 0; i < n; i++) begin
			if (exp_q.size() == 0)
				abort_run("The ring was read past the words the model expects");
			compare_bit("rb_empty", rb_empty, 1'b0);
			@(posedge CLK);
			rb_rd <= 1'b1;
			@(posedge CLK);
			rb_rd <= 1'b0;
			@(negedge CLK);
			exp = exp_q.pop_front();
			compare_word("rb_dout", rb_dout, exp);
			if (hold_idle)
				compare_bit("busy", busy, 1'b0);
		end
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		int tpos;
		RST <= 1'b1;
		slice_we <= 1'b0;
		slice_in <= '0;
		trig <= 1'b0;
		jtag_mode <= 1'b0;
		jtag_rd <= 1'b0;
		rb_rd <= 1'b0;
		lcg_state = 32'd87922;
		trig_cnt = '0;
		repeat (10) @(posedge CLK);
		RST <= 1'b0;
		@(negedge CLK);
		compare_bit("rb_empty", rb_empty, 1'b1);
		compare_bit("busy", busy, 1'b0);

		// Single event
		send_trig();
		repeat (SLICES_PER_EVT) write_slice();
		run_event();
		read_words(EVT_WORDS, 1'b0);

		// Eight events with the trigger at a random place among the slices
		for (int e = 0; e < 8; e++) begin
			tpos = int'(next_rand() % (SLICES_PER_EVT + 1));
			for (int k = 0; k <= SLICES_PER_EVT; k++) begin
				if (k == tpos)
					send_trig();
				if (k < SLICES_PER_EVT)
					write_slice();
			end
			run_event();
			read_words(EVT_WORDS, 1'b0);
		end

		// Trigger ahead of the data
		send_trig();
		for (int k = 0; k < SLICES_PER_EVT - 1; k++) begin
			write_slice();
			@(negedge CLK);
			compare_bit("busy", busy, 1'b0);
		end
		write_slice();
		run_event();
		read_words(EVT_WORDS, 1'b0);

		// Data with no trigger
		repeat (SLICES_PER_EVT) write_slice();
		repeat (20) begin
			@(negedge CLK);
			compare_bit("busy", busy, 1'b0);
		end
		send_trig();
		run_event();
		read_words(EVT_WORDS, 1'b0);

		// Two unread events leave too little room for a third
		repeat (2) begin
			send_trig();
			repeat (SLICES_PER_EVT) write_slice();
			run_event();
		end
		send_trig();
		repeat (SLICES_PER_EVT) write_slice();
		repeat (50) begin
			@(negedge CLK);
			compare_bit("busy", busy, 1'b0);
		end
		read_words(EVT_WORDS - (RB_DEPTH - 2 * EVT_WORDS), 1'b1);
		run_event();
		read_words(exp_q.size(), 1'b0);

		// JTAG pops the first slices before the event is sent
		@(posedge CLK);
		jtag_mode <= 1'b1;
		repeat (SLICES_PER_EVT + 4) write_slice();
		// Pending trigger must wait for the end of JTAG mode
		send_trig();
		@(negedge CLK);
		compare_slice("jtag_slice", jtag_slice, slice_q[0]);
		repeat (4) jtag_pop();
		@(posedge CLK);
		jtag_mode <= 1'b0;
		run_event();
		read_words(EVT_WORDS, 1'b0);

		@(negedge CLK);
		compare_bit("rb_empty", rb_empty, 1'b1);
		if (exp_q.size() != 0 || slice_q.size() != 0) begin
			abort_run("The model still holds data that never came out of the ring");
		end else begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run the sample transfer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module sample_xfer_tb \
	-f verilog.f --Mdir obj_dir -o sim_bin

./obj_dir/sim_bin > sim.log 2>&1 || true
cat sim.log

if grep -q "All checks passed" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

//--- verilog.f
verilog/xfer_pkg.sv
verilog/chan_fifo_bank.sv
verilog/l1a_fifo.sv
verilog/xfer_ctrl.sv
verilog/chan_sequencer.sv
verilog/ring_buffer.sv
verilog/sample_xfer_top.sv
dv/sample_xfer_tb.sv

//--- verilog/chan_fifo_bank.sv
`timescale 1ns/1ns

module chan_fifo_bank
	import xfer_pkg::*;
(
	input  logic                 CLK,
	input  logic                 RST,
	input  logic                 slice_we,
	input  slice_t               slice_in,
	input  logic [NUM_CHAN-1:0]  rd_ena,
	input  logic                 jtag_mode,
	input  logic                 jtag_rd,
	output slice_t               head,
	output slice_t               jtag_slice,
	output logic                 evt_rdy
);

	logic [SAMP_W-1:0] mem [NUM_CHAN][CHAN_FIFO_DEPTH];
	logic [CHAN_FIFO_AW-1:0] wr_ptr;
	logic [CHAN_FIFO_AW-1:0] rd_ptr [NUM_CHAN];
	logic [CHAN_FIFO_AW:0] cnt [NUM_CHAN];
	logic [NUM_CHAN-1:0] pop;
	logic [NUM_CHAN-1:0] rd_ok;
	logic [NUM_CHAN-1:0] full;
	logic [NUM_CHAN-1:0] has_evt;
	logic wr_ok;
	slice_t heads;

	// JTAG pops every channel at once
	assign pop = jtag_mode ? {NUM_CHAN{jtag_rd}} : rd_ena;

	always_comb begin
		for (int c = 0; c < NUM_CHAN; c++) begin
			full[c] = (cnt[c] == (CHAN_FIFO_AW+1)'(CHAN_FIFO_DEPTH));
			rd_ok[c] = pop[c] && (cnt[c] != '0);
			has_evt[c] = (cnt[c] >= (CHAN_FIFO_AW+1)'(SLICES_PER_EVT));
			heads[c] = mem[c][rd_ptr[c]];
		end
	end

	// Slices go in as a whole, so one full channel blocks the write
	assign wr_ok = slice_we && !(|full);

	always_ff @(posedge CLK) begin
		if (wr_ok) begin
			for (int c = 0; c < NUM_CHAN; c++)
				mem[c][wr_ptr] <= slice_in[c];
		end
	end

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			wr_ptr <= '0;
			for (int c = 0; c < NUM_CHAN; c++) begin
				rd_ptr[c] <= '0;
				cnt[c] <= '0;
			end
		end else begin
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;
			for (int c = 0; c < NUM_CHAN; c++) begin
				if (rd_ok[c])
					rd_ptr[c] <= rd_ptr[c] + 1'b1;
				if (wr_ok && !rd_ok[c])
					cnt[c] <= cnt[c] + 1'b1;
				else if (!wr_ok && rd_ok[c])
					cnt[c] <= cnt[c] - 1'b1;
			end
		end
	end

	assign head = heads;
	assign jtag_slice = heads;
	assign evt_rdy = &has_evt;

endmodule

//--- verilog/chan_sequencer.sv
`timescale 1ns/1ns

module chan_sequencer
	import xfer_pkg::*;
(
	input  logic                CLK,
	input  logic                RST,
	input  seq_cmd_t            seq_cmd,
	input  slice_t              head,
	output logic [NUM_CHAN-1:0] rd_ena,
	output sample_t             samp_sel,
	output logic                seq_last
);

	seq_pos_t seq_pos;
	logic chan_wrap;
	logic chip_wrap;
	logic samp_wrap;

	assign chan_wrap = (seq_pos.chan == 4'(NUM_CHAN - 1));
	assign chip_wrap = (seq_pos.chip == 3'(NUM_CHIP - 1));
	assign samp_wrap = (seq_pos.samp == 2'(NUM_SAMP - 1));

	//////////////////////////////
	// Position counters
	//////////////////////////////

	// Channel innermost, then chip, then sample time
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			seq_pos <= '0;
		end else if (seq_cmd.clear) begin
			seq_pos <= '0;
		end else if (seq_cmd.step) begin
			if (chan_wrap) begin
				seq_pos.chan <= '0;
				if (chip_wrap) begin
					seq_pos.chip <= '0;
					seq_pos.samp <= samp_wrap ? '0 : seq_pos.samp + 1'b1;
				end else begin
					seq_pos.chip <= seq_pos.chip + 1'b1;
				end
			end else begin
				seq_pos.chan <= seq_pos.chan + 1'b1;
			end
		end
	end

	//////////////////////////////
	// Read decode and sample mux
	//////////////////////////////

	always_comb begin
		rd_ena = '0;
		rd_ena[seq_pos.chan] = seq_cmd.re;
	end

	assign samp_sel = head[seq_pos.chan];

	// Final position of the event
	assign seq_last = chan_wrap && chip_wrap && samp_wrap;

endmodule

//--- verilog/l1a_fifo.sv
`timescale 1ns/1ns

module l1a_fifo
	import xfer_pkg::*;
(
	input  logic    CLK,
	input  logic    RST,
	input  logic    trig,
	input  logic    l1a_pop,
	output sample_t evt_num,
	output logic    l1a_avail
);

	sample_t mem [L1A_DEPTH];
	sample_t evt_cnt;
	logic [L1A_AW-1:0] wr_ptr;
	logic [L1A_AW-1:0] rd_ptr;
	logic [L1A_AW:0] cnt;
	logic push_ok;
	logic pop_ok;

	assign push_ok = trig && (cnt != (L1A_AW+1)'(L1A_DEPTH));
	assign pop_ok = l1a_pop && (cnt != '0);

	always_ff @(posedge CLK) begin
		if (push_ok)
			mem[wr_ptr] <= evt_cnt;
	end

	// Event number wraps at 12 bits
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			evt_cnt <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt <= '0;
		end else begin
			if (push_ok) begin
				evt_cnt <= evt_cnt + 1'b1;
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_ok)
				rd_ptr <= rd_ptr + 1'b1;
			if (push_ok && !pop_ok)
				cnt <= cnt + 1'b1;
			else if (!push_ok && pop_ok)
				cnt <= cnt - 1'b1;
		end
	end

	assign evt_num = mem[rd_ptr];
	assign l1a_avail = (cnt != '0);

endmodule

//--- verilog/ring_buffer.sv
`timescale 1ns/1ns

module ring_buffer
	import xfer_pkg::*;
(
	input  logic           CLK,
	input  logic           RST,
	input  rb_wr_t         rb_wr,
	input  sample_t        evt_num,
	input  sample_t        samp_sel,
	input  logic           rb_rd,
	output rb_word_t       rb_dout,
	output logic           rb_empty,
	output logic [RB_AW:0] rb_free
);

	rb_word_t mem [RB_DEPTH];
	rb_word_t wdata;
	logic [RB_AW-1:0] wr_ptr;
	logic [RB_AW-1:0] rd_ptr;
	logic [RB_AW:0] cnt;
	logic wr_ok;
	logic rd_ok;

	// Header carries the event number, otherwise the selected sample
	assign wdata.hdr = rb_wr.hdr;
	assign wdata.data = rb_wr.hdr ? evt_num : samp_sel;

	assign wr_ok = rb_wr.we && (cnt != (RB_AW+1)'(RB_DEPTH));
	assign rd_ok = rb_rd && !rb_empty;

	always_ff @(posedge CLK) begin
		if (wr_ok)
			mem[wr_ptr] <= wdata;
		if (rd_ok)
			rb_dout <= mem[rd_ptr];
	end

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt <= '0;
		end else begin
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
			if (wr_ok && !rd_ok)
				cnt <= cnt + 1'b1;
			else if (!wr_ok && rd_ok)
				cnt <= cnt - 1'b1;
		end
	end

	assign rb_empty = (cnt == '0);
	assign rb_free = (RB_AW+1)'(RB_DEPTH) - cnt;

endmodule

//--- verilog/sample_xfer_top.sv
`timescale 1ns/1ns

module sample_xfer_top
	import xfer_pkg::*;
(
	input  logic     CLK,
	input  logic     RST,
	input  logic     slice_we,
	input  slice_t   slice_in,
	input  logic     trig,
	input  logic     jtag_mode,
	input  logic     jtag_rd,
	input  logic     rb_rd,
	output slice_t   jtag_slice,
	output rb_word_t rb_dout,
	output logic     rb_empty,
	output logic     busy
);

	slice_t head;
	logic [NUM_CHAN-1:0] rd_ena;
	logic evt_rdy;
	sample_t evt_num;
	logic l1a_avail;
	logic l1a_pop;
	seq_cmd_t seq_cmd;
	sample_t samp_sel;
	logic seq_last;
	rb_wr_t rb_wr;
	logic [RB_AW:0] rb_free;

	//////////////////////////////
	// Input buffering
	//////////////////////////////

	chan_fifo_bank u_fifo_bank (
		.CLK        (CLK),
		.RST        (RST),
		.slice_we   (slice_we),
		.slice_in   (slice_in),
		.rd_ena     (rd_ena),
		.jtag_mode  (jtag_mode),
		.jtag_rd    (jtag_rd),
		.head       (head),
		.jtag_slice (jtag_slice),
		.evt_rdy    (evt_rdy)
	);

	l1a_fifo u_l1a_fifo (
		.CLK       (CLK),
		.RST       (RST),
		.trig      (trig),
		.l1a_pop   (l1a_pop),
		.evt_num   (evt_num),
		.l1a_avail (l1a_avail)
	);

	//////////////////////////////
	// Transfer path
	//////////////////////////////

	xfer_ctrl u_ctrl (
		.CLK       (CLK),
		.RST       (RST),
		.jtag_mode (jtag_mode),
		.evt_rdy   (evt_rdy),
		.l1a_avail (l1a_avail),
		.rb_free   (rb_free),
		.seq_last  (seq_last),
		.seq_cmd   (seq_cmd),
		.rb_wr     (rb_wr),
		.l1a_pop   (l1a_pop),
		.busy      (busy)
	);

	chan_sequencer u_seq (
		.CLK      (CLK),
		.RST      (RST),
		.seq_cmd  (seq_cmd),
		.head     (head),
		.rd_ena   (rd_ena),
		.samp_sel (samp_sel),
		.seq_last (seq_last)
	);

	ring_buffer u_ring (
		.CLK      (CLK),
		.RST      (RST),
		.rb_wr    (rb_wr),
		.evt_num  (evt_num),
		.samp_sel (samp_sel),
		.rb_rd    (rb_rd),
		.rb_dout  (rb_dout),
		.rb_empty (rb_empty),
		.rb_free  (rb_free)
	);

endmodule

//--- verilog/xfer_ctrl.sv
`timescale 1ns/1ns

module xfer_ctrl
	import xfer_pkg::*;
(
	input  logic           CLK,
	input  logic           RST,
	input  logic           jtag_mode,
	input  logic           evt_rdy,
	input  logic           l1a_avail,
	input  logic [RB_AW:0] rb_free,
	input  logic           seq_last,
	output seq_cmd_t       seq_cmd,
	output rb_wr_t         rb_wr,
	output logic           l1a_pop,
	output logic           busy
);

	xfer_state_e state;
	xfer_state_e state_nxt;
	logic room;
	logic start;

	//////////////////////////////
	// Start conditions
	//////////////////////////////

	// Whole event must fit in the ring
	assign room = (rb_free >= (RB_AW+1)'(EVT_WORDS));
	assign start = !jtag_mode && evt_rdy && l1a_avail && room;

	//////////////////////////////
	// State register
	//////////////////////////////

	always_ff @(posedge CLK or posedge RST) begin
		if (RST)
			state <= ST_IDLE;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (start)
					state_nxt = ST_HEADER;
			end
			ST_HEADER:
				state_nxt = ST_XFER;
			ST_XFER: begin
				// Last sample written this cycle
				if (seq_last && seq_cmd.step)
					state_nxt = ST_DONE;
			end
			ST_DONE:
				state_nxt = ST_IDLE;
			default:
				state_nxt = ST_IDLE;
		endcase
	end

	//////////////////////////////
	// Strobes per state
	//////////////////////////////

	always_comb begin
		seq_cmd = '0;
		rb_wr = '0;
		l1a_pop = 1'b0;
		case (state)
			ST_HEADER: begin
				l1a_pop = 1'b1;
				rb_wr.we = 1'b1;
				rb_wr.hdr = 1'b1;
				seq_cmd.clear = 1'b1;
			end
			ST_XFER: begin
				seq_cmd.re = 1'b1;
				seq_cmd.step = 1'b1;
				rb_wr.we = seq_cmd.re;
			end
			default: ;
		endcase
	end

	assign busy = (state != ST_IDLE);

endmodule

//--- verilog/xfer_pkg.sv
package xfer_pkg;

	//////////////////////////////
	// Geometry
	//////////////////////////////

	localparam int NUM_CHAN = 16;
	localparam int NUM_CHIP = 6;
	localparam int NUM_SAMP = 4;
	localparam int SAMP_W = 12;

	// One slice word per chip per sample time
	localparam int SLICES_PER_EVT = NUM_SAMP * NUM_CHIP;
	// Header word plus every sample of the event
	localparam int EVT_WORDS = 1 + SLICES_PER_EVT * NUM_CHAN;

	// Buffer sizes
	localparam int CHAN_FIFO_DEPTH = 64;
	localparam int CHAN_FIFO_AW = $clog2(CHAN_FIFO_DEPTH);
	localparam int L1A_DEPTH = 8;
	localparam int L1A_AW = $clog2(L1A_DEPTH);
	localparam int RB_DEPTH = 1024;
	localparam int RB_AW = 10;

	//////////////////////////////
	// Data types
	//////////////////////////////

	typedef logic [SAMP_W-1:0] sample_t;

	// Channel 0 sits in the low bits
	typedef sample_t [NUM_CHAN-1:0] slice_t;

	typedef struct packed {
		logic hdr;
		sample_t data;
	} rb_word_t;

	typedef struct packed {
		logic clear;
		logic step;
		logic re;
	} seq_cmd_t;

	typedef struct packed {
		logic [3:0] chan;
		logic [2:0] chip;
		logic [1:0] samp;
	} seq_pos_t;

	typedef struct packed {
		logic we;
		logic hdr;
	} rb_wr_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_HEADER,
		ST_XFER,
		ST_DONE
	} xfer_state_e;

endpackage
